//--- design/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  resp_t;

    // AXI read response codes.
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Cache geometry with one 32-bit word per line.
    localparam int ICACHE_LINES = 16;
    localparam int OFFSET_W     = 2;
    localparam int INDEX_W      = 4;
    localparam int TAG_W        = 26;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // Fetch control states.
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        CHECK,
        AR,
        R,
        FILL,
        DELIVER
    } ifu_state_t;

endpackage

//--- design/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic              clk,
    input  logic              rst,

    input  fetch_pkg::addr_t  pc,
    input  logic              pc_valid,
    output logic              pc_ready,

    output fetch_pkg::inst_t  inst,
    output logic              inst_fault,
    output logic              inst_valid,
    input  logic              inst_ready,

    output fetch_pkg::addr_t  araddr,
    output logic              arvalid,
    input  logic              arready,

    input  fetch_pkg::inst_t  rdata,
    input  fetch_pkg::resp_t  rresp,
    input  logic              rvalid,
    output logic              rready,

    output logic              lookup_req,
    output fetch_pkg::addr_t  lookup_addr,
    output logic              fill_en,
    output fetch_pkg::addr_t  fill_addr,
    output fetch_pkg::inst_t  fill_data,
    input  logic              hit,
    input  fetch_pkg::inst_t  hit_data
);

    import fetch_pkg::*;

    ifu_state_t state;
    ifu_state_t state_d;

    addr_t pc_q;

    logic pc_take;
    logic r_take;
    logic hit_take;
    logic r_okay;

    assign pc_take  = pc_valid && pc_ready;
    assign r_take   = rvalid && rready;
    assign hit_take = (state == CHECK) && hit;
    assign r_okay   = (rresp == RESP_OKAY);

    always_comb begin
        state_d = state;
        case (state)
            IDLE: begin
                if (pc_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = CHECK;
            end
            CHECK: begin
                state_d = hit ? DELIVER : AR;
            end
            AR: begin
                if (arready) begin
                    state_d = R;
                end
            end
            R: begin
                // A faulting read skips the refill and goes straight to the decoder.
                if (rvalid) begin
                    state_d = r_okay ? FILL : DELIVER;
                end
            end
            FILL: begin
                state_d = DELIVER;
            end
            DELIVER: begin
                if (inst_ready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_fault <= 1'b0;
        end else if (hit_take) begin
            inst_fault <= 1'b0;
        end else if (r_take) begin
            inst_fault <= !r_okay;
        end
    end

    // Fetch address and instruction word.
    always_ff @(posedge clk) begin
        if (pc_take) begin
            pc_q <= pc;
        end
        if (hit_take) begin
            inst <= hit_data;
        end else if (r_take) begin
            inst <= rdata;
        end
    end

    assign pc_ready   = (state == IDLE);
    assign inst_valid = (state == DELIVER);

    // araddr comes from a register, so it stays stable while arvalid waits.
    assign arvalid = (state == AR);
    assign araddr  = pc_q;
    assign rready  = (state == R);

    assign lookup_req  = (state == LOOKUP);
    assign lookup_addr = pc_q;

    // Refill uses the word just captured from the R channel.
    assign fill_en   = (state == FILL);
    assign fill_addr = pc_q;
    assign fill_data = inst;

endmodule

//--- design/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,

    input  logic              lookup_req,
    input  fetch_pkg::addr_t  lookup_addr,

    input  logic              fill_en,
    input  fetch_pkg::addr_t  fill_addr,
    input  fetch_pkg::inst_t  fill_data,

    output logic              hit,
    output fetch_pkg::inst_t  hit_data
);

    import fetch_pkg::*;

    logic [ICACHE_LINES-1:0] line_valid;
    tag_t                    line_tag  [ICACHE_LINES];
    inst_t                   line_data [ICACHE_LINES];

    index_t lookup_index;
    tag_t   lookup_tag;
    index_t fill_index;
    tag_t   fill_tag;

    logic   tag_match;

    // Address splits into tag, index and byte offset.
    assign lookup_index = lookup_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag   = lookup_addr[OFFSET_W + INDEX_W +: TAG_W];
    assign fill_index   = fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag     = fill_addr[OFFSET_W + INDEX_W +: TAG_W];

    assign tag_match = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);

    // Flush wins over a fill in the same cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_valid <= '0;
        end else if (flush) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill_data;
        end
    end

    // Lookup result is registered and shows up one cycle after the request.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup_req && !flush && tag_match;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            hit_data <= line_data[lookup_index];
        end
    end

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic              clk,
    input  logic              rst,

    input  fetch_pkg::addr_t  pc,
    input  logic              pc_valid,
    output logic              pc_ready,

    output fetch_pkg::inst_t  inst,
    output logic              inst_fault,
    output logic              inst_valid,
    input  logic              inst_ready,

    input  logic              flush,

    output fetch_pkg::addr_t  araddr,
    output logic              arvalid,
    input  logic              arready,

    input  fetch_pkg::inst_t  rdata,
    input  fetch_pkg::resp_t  rresp,
    input  logic              rvalid,
    output logic              rready
);

    import fetch_pkg::*;

    logic  lookup_req;
    addr_t lookup_addr;
    logic  fill_en;
    addr_t fill_addr;
    inst_t fill_data;
    logic  hit;
    inst_t hit_data;

    ifu ifu_i (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .pc_valid    (pc_valid),
        .pc_ready    (pc_ready),
        .inst        (inst),
        .inst_fault  (inst_fault),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    // Flush bypasses the fetch FSM and goes straight to the cache (fence.i).
    icache icache_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .lookup_req  (lookup_req),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .hit         (hit),
        .hit_data    (hit_data)
    );

endmodule

//--- test/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int TIMEOUT = 100;

    logic  clk = 1'b0;
    logic  rst;
    addr_t pc;
    logic  pc_valid;
    logic  pc_ready;
    inst_t inst;
    logic  inst_fault;
    logic  inst_valid;
    logic  inst_ready;
    logic  flush;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    inst_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;

    // Memory image and SLVERR addresses taken from the test file.
    inst_t mem_img [addr_t];
    bit    err_set [addr_t];

    logic [7:0] cmd_kind [$];
    addr_t      cmd_addr [$];
    logic       cmd_hit  [$];

    int    errors = 0;
    int    checks = 0;
    int    ar_count = 0;
    addr_t last_araddr = '0;
    bit    aborted = 1'b0;

    fetch_unit dut_i (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .pc_valid   (pc_valid),
        .pc_ready   (pc_ready),
        .inst       (inst),
        .inst_fault (inst_fault),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .flush      (flush),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    always #50 clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic abort_run(input string what);
        ifu_state_t fsm;
        fsm = dut_i.ifu_i.state;
        errors++;
        aborted = 1'b1;
        $display("timeout: no %s within %0d cycles at %0d ns, fetch FSM in %s",
                 what, TIMEOUT, $time, fsm.name());
    endtask

    // Words missing from the image get a pattern built from the whole address.
    function automatic inst_t mem_word(input addr_t addr);
        if (mem_img.exists(addr)) begin
            return mem_img[addr];
        end
        return {addr[15:0] ^ 16'h5a3c, addr[31:16]};
    endfunction

    task automatic load_tests();
        int                 fd;
        logic [7:0]         tok;
        logic [7:0]         flag;
        addr_t              a;
        inst_t              d;
        logic [8*160-1:0]   rest;
        fd = $fopen("test/fetch_unit_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            aborted = 1'b1;
            $display("could not open test/fetch_unit_tests.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                void'($fgets(rest, fd));
            end else if (tok == "m") begin
                void'($fscanf(fd, "%h %h", a, d));
                mem_img[a] = d;
            end else if (tok == "e") begin
                void'($fscanf(fd, "%h", a));
                err_set[a] = 1'b1;
            end else if (tok == "f") begin
                void'($fscanf(fd, "%h %s", a, flag));
                cmd_kind.push_back(tok);
                cmd_addr.push_back(a);
                cmd_hit.push_back(flag == "h");
            end else if (tok == "x" || tok == "s") begin
                cmd_kind.push_back(tok);
                cmd_addr.push_back('0);
                cmd_hit.push_back(1'b0);
            end else begin
                errors++;
                $display("unknown command %s in the test file", tok);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle_outputs();
        check_bit("arvalid", 1'b0, arvalid);
        check_bit("rready", 1'b0, rready);
        check_bit("inst_valid", 1'b0, inst_valid);
        check_bit("pc_ready", 1'b1, pc_ready);
    endtask

    task automatic run_fetch(input addr_t addr, input logic exp_hit, input int stall);
        int    cycles;
        int    start_ar;
        inst_t exp_inst;
        logic  exp_fault;
        inst_t held_inst;
        logic  held_fault;
        exp_inst  = mem_word(addr);
        exp_fault = (err_set.exists(addr) != 0);
        cycles = 0;
        while (!pc_ready && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!pc_ready) begin
            abort_run("pc_ready");
            return;
        end
        start_ar = ar_count;
        pc       = addr;
        pc_valid = 1'b1;
        @(negedge clk);
        pc_valid = 1'b0;
        // Counts cycles from the accepting edge up to the first DELIVER cycle.
        cycles = 1;
        while (!inst_valid && cycles < TIMEOUT) begin
            check_bit("pc_ready", 1'b0, pc_ready);
            @(negedge clk);
            cycles++;
        end
        if (!inst_valid) begin
            abort_run("inst_valid");
            return;
        end
        check_word("inst", exp_inst, inst);
        check_bit("inst_fault", exp_fault, inst_fault);
        if (exp_hit) begin
            check_word("AR handshakes", 0, ar_count - start_ar);
            check_word("hit latency", 3, cycles);
        end else begin
            check_word("AR handshakes", 1, ar_count - start_ar);
            check_word("araddr", addr, last_araddr);
        end
        held_inst  = inst;
        held_fault = inst_fault;
        repeat (stall) begin
            @(negedge clk);
            check_bit("inst_valid", 1'b1, inst_valid);
            check_word("inst", held_inst, inst);
            check_bit("inst_fault", held_fault, inst_fault);
            check_bit("pc_ready", 1'b0, pc_ready);
        end
        inst_ready = 1'b1;
        @(negedge clk);
        inst_ready = 1'b0;
        // The decoder took one word and the FSM is back in IDLE.
        check_bit("inst_valid", 1'b0, inst_valid);
        check_bit("pc_ready", 1'b1, pc_ready);
    endtask

    // AXI read slave with random AR and R latency.
    initial begin : axi_slave
        addr_t req_addr;
        int    delay;
        int    n;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = RESP_OKAY;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                req_addr = araddr;
                delay = $urandom_range(0, 5);
                repeat (delay) begin
                    @(negedge clk);
                    check_bit("arvalid", 1'b1, arvalid);
                    check_word("araddr", req_addr, araddr);
                end
                arready = 1'b1;
                ar_count++;
                last_araddr = req_addr;
                @(negedge clk);
                arready = 1'b0;
                delay = $urandom_range(0, 5);
                repeat (delay) @(negedge clk);
                n = 0;
                while (!rready && n < TIMEOUT) begin
                    @(negedge clk);
                    n++;
                end
                if (!rready) begin
                    abort_run("rready");
                end else begin
                    rvalid = 1'b1;
                    rdata  = mem_word(req_addr);
                    rresp  = err_set.exists(req_addr) ? RESP_SLVERR : RESP_OKAY;
                    @(negedge clk);
                    rvalid = 1'b0;
                    rdata  = '0;
                    rresp  = RESP_OKAY;
                end
            end
        end
    end

    initial begin : main_seq
        int idx;
        int stall;
        void'($urandom(32'h1648_1877));
        rst        = 1'b1;
        pc         = '0;
        pc_valid   = 1'b0;
        inst_ready = 1'b0;
        flush      = 1'b0;
        load_tests();
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        stall = 0;
        idx = 0;
        while (idx < cmd_kind.size() && !aborted) begin
            if (cmd_kind[idx] == "f") begin
                run_fetch(cmd_addr[idx], cmd_hit[idx], stall);
                stall = 0;
            end else if (cmd_kind[idx] == "x") begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end else begin
                stall = $urandom_range(1, 6);
            end
            idx++;
        end
        $display("checks: %0d, errors: %0d, AR handshakes: %0d", checks, errors, ar_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- fetch_unit.f
design/fetch_pkg.sv
design/ifu.sv
design/icache.sv
design/fetch_unit.sv
test/fetch_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -sv \
    --top-module fetch_unit_tb \
    -f fetch_unit.f \
    -Mdir obj_dir \
    -o fetch_unit_sim

./obj_dir/fetch_unit_sim 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"

//--- test/fetch_unit_tests.txt
# m <addr> <word> is a memory word, e <addr> is an address that answers SLVERR
# f <addr> <h|m> is a fetch with its expected hit or miss, x is a flush, s stalls the next fetch
m 00001000 00a00093
m 00001004 00b00113
m 00001040 002081b3
m 00002008 40110233
m 0000300c deadbeef
e 0000300c
f 00001000 m # first fetch after reset
f 00001000 h
f 00001004 m
f 00001004 h
f 00002008 m
s
f 00002008 h
f 00001040 m # same index as 00001000
f 00001040 h
f 00001000 m
f 00001040 m
x
f 00001000 m
f 00001004 m
f 00002008 m
f 00001004 h
s
f 0000300c m # SLVERR
s
f 0000300c m # faulting reads never refill
f 00001010 m # not in the image
s
f 00001010 h
f 00001004 h
